/* dv/regRead_input.txt */
// inValid src1 src2 dest mask mispredict ckptId outReady wbV0 wbTag0 wbData0 wbV1 wbTag1 wbData1
//   allocValid allocTag exception, all hex, one line per cycle
0 00 00 00 0 0 0 1 1 08 aaaa0008 1 09 bbbb0009 1 0c 0
1 08 09 10 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
1 09 08 11 0 0 0 1 1 0a 1111000a 1 0b 2222000b 0 00 0
1 0a 0b 12 0 0 0 1 1 0a 3333000a 1 0a 4444000a 0 00 0
1 0b 0c 13 0 0 0 1 1 0c 5555000c 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
1 08 0a 14 0 0 0 0 0 00 00000000 0 00 00000000 0 00 0
1 09 0b 15 0 0 0 0 0 00 00000000 0 00 00000000 0 00 0
1 0c 08 16 0 0 0 0 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 0 0 00 00000000 0 00 00000000 0 00 0
1 0c 08 16 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
1 08 09 17 1 0 0 0 0 00 00000000 0 00 00000000 0 00 0
1 09 0a 18 2 0 0 0 0 00 00000000 0 00 00000000 0 00 0
1 0a 0b 19 1 1 0 0 0 00 00000000 0 00 00000000 0 00 0
1 0b 0c 1a 4 1 2 1 0 00 00000000 0 00 00000000 0 00 0
1 0c 0c 1b 3 0 0 1 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 1 03 0
0 00 00 00 0 0 0 1 1 03 00000033 0 00 00000000 1 03 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 1 05 0
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 1
0 00 00 00 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0
1 03 05 1c 0 0 0 1 0 00 00000000 0 00 00000000 0 00 0

/* sim.f */
verilog/regReadPkg.sv
verilog/branchPkg.sv
verilog/readStageIf.sv
verilog/physRegFile.sv
verilog/bypassCapture.sv
verilog/operandMerge.sv
verilog/readyScoreboard.sv
verilog/regRead.sv
dv/regRead_properties.sv
dv/regReadTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run from the project root, then search the log for the fail message
verilator --binary --timing --assert -f sim.f --top-module regReadTb -o regReadSim > build.log 2>&1 \
  && ./obj_dir/regReadSim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0

/* dv/regReadTb.sv */
// Testbench for regRead that replays the input file, then random cycles, against a model
`timescale 1ns/100ps
`default_nettype none

module regReadTb;

  localparam int RAND_N = 200;
  localparam logic [31:0] ARCH_SET = (32'd1 << regReadPkg::NUM_ARCH) - 32'd1;

  logic clk = 1'b0;
  logic rst_i;
  logic inValid_i, outReady_i, mispredict_i, allocValid_i, exception_i;
  logic inReady_o, outValid_o;
  regReadPkg::pregTag_t inSrc1_i, inSrc2_i, inDest_i, allocTag_i, outDest_o;
  branchPkg::branchMask_t inMask_i;
  branchPkg::ckptId_t ckptId_i;
  regReadPkg::regData_t outData1_o, outData2_o;
  logic [1:0] wbValid_i;
  regReadPkg::pregTag_t [1:0] wbTag_i;
  regReadPkg::regData_t [1:0] wbData_i;
  regReadPkg::pregVec_t phyRegRdy_o;

  logic [31:0] stim [64][17];  // One row per file line, columns as in the file
  logic [31:0] cur [17];
  int lineCount = 0;
  logic loaded = 1'b0;

  // Slot 0 models stage 1 and slot 1 the output register
  logic [31:0] mRegs [32];
  logic [31:0] mRdy;
  logic mValid [2];
  logic [4:0] mDest [2];
  logic [31:0] mD1 [2];
  logic [31:0] mD2 [2];
  logic [3:0] mMask [2];

  always #5 clk = !clk;

  regRead dut_i (.*);

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Value a source sees at acceptance including same-cycle writebacks
  function automatic logic [31:0] forwardValue(input logic [31:0] tag);
    logic [31:0] val;
    val = mRegs[tag[4:0]];
    if (cur[8][0] && cur[9][4:0] == tag[4:0]) val = cur[10];
    if (cur[11][0] && cur[12][4:0] == tag[4:0]) val = cur[13];  // Port 1 wins
    return val;
  endfunction

  task automatic loadStimulus();
    int fd;
    int cnt;
    string line;
    fd = $fopen("dv/regRead_input.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open the stimulus file");
      $display("Finished with errors");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.len() < 3 || line.substr(0, 1) == "//") continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        stim[lineCount][0], stim[lineCount][1], stim[lineCount][2], stim[lineCount][3],
        stim[lineCount][4], stim[lineCount][5], stim[lineCount][6], stim[lineCount][7],
        stim[lineCount][8], stim[lineCount][9], stim[lineCount][10], stim[lineCount][11],
        stim[lineCount][12], stim[lineCount][13], stim[lineCount][14], stim[lineCount][15],
        stim[lineCount][16]);
      if (cnt == 17) lineCount++;
    end
    $fclose(fd);
  endtask

  // Applies the current stimulus row to the DUT inputs
  task automatic driveInputs();
    inValid_i = cur[0][0];
    inSrc1_i = cur[1][4:0];
    inSrc2_i = cur[2][4:0];
    inDest_i = cur[3][4:0];
    inMask_i = cur[4][3:0];
    mispredict_i = cur[5][0];
    ckptId_i = cur[6][1:0];
    outReady_i = cur[7][0];
    wbValid_i = {cur[11][0], cur[8][0]};
    wbTag_i[0] = cur[9][4:0];
    wbData_i[0] = cur[10];
    wbTag_i[1] = cur[12][4:0];
    wbData_i[1] = cur[13];
    allocValid_i = cur[14][0];
    allocTag_i = cur[15][4:0];
    exception_i = cur[16][0];
  endtask

  task automatic stepCycle(input string name);
    logic step;
    logic acc;
    logic killIn;
    logic [1:0] ck;
    @(negedge clk);
    driveInputs();
    #1;
    step = !mValid[1] || cur[7][0];
    checkValue({name, " outValid"}, 32'(mValid[1]), 32'(outValid_o));
    checkValue({name, " inReady"}, 32'(step), 32'(inReady_o));
    if (mValid[1]) begin
      checkValue({name, " outDest"}, 32'(mDest[1]), 32'(outDest_o));
      checkValue({name, " outData1"}, mD1[1], outData1_o);
      checkValue({name, " outData2"}, mD2[1], outData2_o);
    end
    checkValue({name, " phyRegRdy"}, mRdy, phyRegRdy_o);
    // ************************************************************
    // Model update for the coming clock edge
    // ************************************************************
    ck = cur[6][1:0];
    acc = cur[0][0] && step;
    killIn = cur[5][0] && cur[4][ck];
    if (step) begin
      mValid[1] = mValid[0] && !(cur[5][0] && mMask[0][ck]);
      mDest[1] = mDest[0];
      mD1[1] = mD1[0];
      mD2[1] = mD2[0];
      mMask[1] = mMask[0];
      mValid[0] = acc && !killIn;
      mDest[0] = cur[3][4:0];
      mD1[0] = forwardValue(cur[1]);
      mD2[0] = forwardValue(cur[2]);
      mMask[0] = cur[4][3:0];
    end else begin
      mValid[0] = mValid[0] && !(cur[5][0] && mMask[0][ck]);
      mValid[1] = mValid[1] && !(cur[5][0] && mMask[1][ck]);
    end
    if (cur[16][0]) begin
      mRdy = ARCH_SET;
    end else begin
      if (cur[14][0]) mRdy[cur[15][4:0]] = 1'b0;
      if (cur[8][0]) mRdy[cur[9][4:0]] = 1'b1;
      if (cur[11][0]) mRdy[cur[12][4:0]] = 1'b1;
    end
    if (cur[8][0]) mRegs[cur[9][4:0]] = cur[10];
    if (cur[11][0]) mRegs[cur[12][4:0]] = cur[13];
  endtask

  initial begin
    wait (loaded);
    #((lineCount + RAND_N + 20) * 10);
    $display("watchdog expired before the tests completed");
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    void'($urandom(6));
    rst_i = 1'b1;
    for (int k = 0; k < 17; k++) cur[k] = '0;
    driveInputs();
    for (int r = 0; r < 32; r++) mRegs[r] = '0;
    mRdy = ARCH_SET;
    mValid[0] = 0;
    mValid[1] = 0;
    loadStimulus();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    #1;
    checkValue("reset outValid", 32'd0, 32'(outValid_o));
    checkValue("reset phyRegRdy", ARCH_SET, phyRegRdy_o);
    for (int i = 0; i < lineCount; i++) begin
      for (int k = 0; k < 17; k++) cur[k] = stim[i][k];
      stepCycle($sformatf("directed line %0d", i));
    end
    for (int i = 0; i < RAND_N; i++) begin
      cur[0] = $urandom % 2;
      cur[1] = $urandom % 32;
      cur[2] = $urandom % 32;
      cur[3] = $urandom % 32;
      cur[4] = $urandom % 16;
      cur[5] = 32'(($urandom % 8) == 0);
      cur[6] = $urandom % 4;
      cur[7] = 32'(($urandom % 4) != 0);
      cur[8] = $urandom % 2;
      cur[9] = $urandom % 32;
      cur[10] = $urandom;
      cur[11] = $urandom % 2;
      cur[12] = $urandom % 32;
      cur[13] = $urandom;
      cur[14] = $urandom % 2;
      cur[15] = $urandom % 32;
      cur[16] = 32'(($urandom % 32) == 0);
      stepCycle($sformatf("random cycle %0d", i));
    end
    for (int k = 0; k < 17; k++) cur[k] = '0;
    cur[7] = 32'd1;  // Drain what is left in the pipe
    repeat (4) stepCycle("drain");
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/regRead_properties.sv */
// Concurrent checks on the read-stage handshake, bound into operandMerge
`timescale 1ns/100ps
`default_nettype none

module regReadProperties (
  input wire                       clk,
  input wire                       rst_i,
  input wire                       inValid_i,
  input wire                       inReady_o,
  input wire                       killIn,
  input wire                       s1Valid,
  input wire                       outValid_o,
  input wire                       outReady_i,
  input wire                       mispredict_i,
  input wire regReadPkg::pregTag_t outDest_o,
  input wire regReadPkg::regData_t outData1_o,
  input wire regReadPkg::regData_t outData2_o
);

  // **********************************************************
  // Reset and handshake rules
  // **********************************************************
  resetEmpty: assert property (@(posedge clk) rst_i |=> !outValid_o)
    else $error("output valid after reset");

  // Only a squash may take away a stalled output
  stallKeep: assert property (@(posedge clk)
    (outValid_o && !outReady_i && !rst_i && !mispredict_i) |=> outValid_o)
    else $error("stalled output dropped");

  stallStable: assert property (@(posedge clk) (outValid_o && !outReady_i && !rst_i)
    |=> ($stable(outDest_o) && $stable(outData1_o) && $stable(outData2_o)))
    else $error("stalled output changed");

  // Ready means the offered instruction is really taken into stage 1
  readyAccepts: assert property (@(posedge clk)
    (inValid_i && inReady_o && !killIn && !rst_i) |=> s1Valid)
    else $error("instruction offered while ready did not enter stage 1");

endmodule

bind operandMerge regReadProperties propsI (
  .clk(clk), .rst_i(rst_i), .inValid_i(inValid_i), .inReady_o(inReady_o),
  .killIn(killIn), .s1Valid(s1Valid), .outValid_o(outValid_o),
  .outReady_i(outReady_i), .mispredict_i(mispredict_i), .outDest_o(outDest_o),
  .outData1_o(outData1_o), .outData2_o(outData2_o)
);

`default_nettype wire

/* verilog/regRead.sv */
// Top of the register-read stage, connecting file, bypass, merge and scoreboard by plain ports
`timescale 1ns/100ps
`default_nettype none

module regRead #(
  parameter int numPreg = regReadPkg::NUM_PREG,
  parameter int numWb   = regReadPkg::NUM_WB
) (
  input wire                                   clk,
  input wire                                   rst_i,
  input wire                                   inValid_i,
  output logic                                 inReady_o,
  input wire regReadPkg::pregTag_t             inSrc1_i,
  input wire regReadPkg::pregTag_t             inSrc2_i,
  input wire regReadPkg::pregTag_t             inDest_i,
  input wire branchPkg::branchMask_t           inMask_i,
  input wire                                   mispredict_i,
  input wire branchPkg::ckptId_t               ckptId_i,
  output logic                                 outValid_o,
  input wire                                   outReady_i,
  output regReadPkg::pregTag_t                 outDest_o,
  output regReadPkg::regData_t                 outData1_o,
  output regReadPkg::regData_t                 outData2_o,
  input wire [numWb-1:0]                       wbValid_i,
  input wire regReadPkg::pregTag_t [numWb-1:0] wbTag_i,
  input wire regReadPkg::regData_t [numWb-1:0] wbData_i,
  input wire                                   allocValid_i,
  input wire regReadPkg::pregTag_t             allocTag_i,
  input wire                                   exception_i,
  output regReadPkg::pregVec_t                 phyRegRdy_o
);

  readStageIf rsIf ();

  // **********************************************************
  // Operand sources, working side by side
  // **********************************************************
  physRegFile #(.numPreg(numPreg), .numWb(numWb)) uRegFile (
    .clk(clk), .rst_i(rst_i),
    .wbValid_i(wbValid_i), .wbTag_i(wbTag_i), .wbData_i(wbData_i),
    .rd(rsIf.regFile)
  );

  bypassCapture #(.numWb(numWb)) uBypass (
    .clk(clk), .rst_i(rst_i),
    .wbValid_i(wbValid_i), .wbTag_i(wbTag_i), .wbData_i(wbData_i),
    .byp(rsIf.bypass)
  );

  operandMerge uMerge (
    .clk(clk), .rst_i(rst_i),
    .inValid_i(inValid_i), .inReady_o(inReady_o),
    .inSrc1_i(inSrc1_i), .inSrc2_i(inSrc2_i), .inDest_i(inDest_i), .inMask_i(inMask_i),
    .mispredict_i(mispredict_i), .ckptId_i(ckptId_i),
    .outValid_o(outValid_o), .outReady_i(outReady_i), .outDest_o(outDest_o),
    .outData1_o(outData1_o), .outData2_o(outData2_o),
    .ops(rsIf.merge)
  );

  readyScoreboard #(.numPreg(numPreg), .numWb(numWb)) uScoreboard (
    .clk(clk), .rst_i(rst_i), .exception_i(exception_i),
    .allocValid_i(allocValid_i), .allocTag_i(allocTag_i),
    .wbValid_i(wbValid_i), .wbTag_i(wbTag_i),
    .phyRegRdy_o(phyRegRdy_o)
  );

endmodule

`default_nettype wire

/* verilog/readyScoreboard.sv */
// Ready flag per physical register, cleared on allocation and set again by writeback
`timescale 1ns/100ps
`default_nettype none

module readyScoreboard #(
  parameter int numPreg = regReadPkg::NUM_PREG,
  parameter int numWb   = regReadPkg::NUM_WB
) (
  input wire                                   clk,
  input wire                                   rst_i,
  input wire                                   exception_i,
  input wire                                   allocValid_i,
  input wire regReadPkg::pregTag_t             allocTag_i,
  input wire [numWb-1:0]                       wbValid_i,
  input wire regReadPkg::pregTag_t [numWb-1:0] wbTag_i,
  output regReadPkg::pregVec_t                 phyRegRdy_o
);

  logic [numPreg-1:0] rdyBits;

  always_ff @(posedge clk) begin
    if (rst_i || exception_i) begin
      // Only the architectural mappings hold committed values
      for (int i = 0; i < numPreg; i++) begin
        rdyBits[i] <= (i < regReadPkg::NUM_ARCH);
      end
    end else begin
      if (allocValid_i) begin
        rdyBits[allocTag_i] <= 1'b0;
      end
      for (int p = 0; p < numWb; p++) begin
        if (wbValid_i[p]) begin
          rdyBits[wbTag_i[p]] <= 1'b1;  // Comes last so it beats an allocation of the same tag
        end
      end
    end
  end

  assign phyRegRdy_o = regReadPkg::pregVec_t'(rdyBits);

endmodule

`default_nettype wire

/* verilog/operandMerge.sv */
// Two-entry read pipe that selects operands, squashes on mispredict and handles the handshakes
`timescale 1ns/100ps
`default_nettype none

module operandMerge (
  input wire                           clk,
  input wire                           rst_i,
  input wire                           inValid_i,
  output logic                         inReady_o,
  input wire regReadPkg::pregTag_t     inSrc1_i,
  input wire regReadPkg::pregTag_t     inSrc2_i,
  input wire regReadPkg::pregTag_t     inDest_i,
  input wire branchPkg::branchMask_t   inMask_i,
  input wire                           mispredict_i,
  input wire branchPkg::ckptId_t       ckptId_i,
  output logic                         outValid_o,
  input wire                           outReady_i,
  output regReadPkg::pregTag_t         outDest_o,
  output regReadPkg::regData_t         outData1_o,
  output regReadPkg::regData_t         outData2_o,
  readStageIf.merge                    ops
);

  logic                   s1Valid;
  regReadPkg::pregTag_t   s1Dest;
  branchPkg::branchMask_t s1Mask;
  branchPkg::branchMask_t outMask;
  logic                   accept;
  logic                   killIn;
  logic                   killS1;
  logic                   killOut;
  regReadPkg::regData_t   opnd1;
  regReadPkg::regData_t   opnd2;

  // **********************************************************
  // Handshake and operand selection
  // **********************************************************
  assign ops.stepEn  = !outValid_o || outReady_i;  // Output slot frees up this cycle
  assign inReady_o   = ops.stepEn;
  assign accept      = inValid_i && ops.stepEn;
  assign ops.srcTag1 = inSrc1_i;
  assign ops.srcTag2 = inSrc2_i;

  assign killIn  = mispredict_i && inMask_i[ckptId_i];
  assign killS1  = mispredict_i && s1Mask[ckptId_i];
  assign killOut = mispredict_i && outMask[ckptId_i];

  // A same-cycle writeback is newer than what the file read returned
  assign opnd1 = ops.bypHit1 ? ops.bypData1 : ops.fileData1;
  assign opnd2 = ops.bypHit2 ? ops.bypData2 : ops.fileData2;

  // **********************************************************
  // Stage 1 and output register
  // **********************************************************
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1Valid    <= 1'b0;
      outValid_o <= 1'b0;
    end else if (ops.stepEn) begin
      s1Valid    <= accept && !killIn;
      outValid_o <= s1Valid && !killS1;
    end else begin
      // Stalled, but a mispredict still removes dependent work
      s1Valid    <= s1Valid && !killS1;
      outValid_o <= outValid_o && !killOut;
    end
  end

  always_ff @(posedge clk) begin
    if (ops.stepEn) begin
      s1Dest     <= inDest_i;
      s1Mask     <= inMask_i;
      outDest_o  <= s1Dest;
      outMask    <= s1Mask;
      outData1_o <= opnd1;
      outData2_o <= opnd2;
    end
  end

endmodule

`default_nettype wire

/* verilog/bypassCapture.sv */
// Catches writeback results that arrive in the same cycle as the source tags they match
`timescale 1ns/100ps
`default_nettype none

module bypassCapture #(
  parameter int numWb = regReadPkg::NUM_WB
) (
  input wire                                   clk,
  input wire                                   rst_i,
  input wire [numWb-1:0]                       wbValid_i,
  input wire regReadPkg::pregTag_t [numWb-1:0] wbTag_i,
  input wire regReadPkg::regData_t [numWb-1:0] wbData_i,
  readStageIf.bypass                           byp
);

  logic                 hit1;
  logic                 hit2;
  regReadPkg::regData_t data1;
  regReadPkg::regData_t data2;

  // Same priority as the register file write so the last matching port is kept
  always_comb begin
    hit1  = 1'b0;
    hit2  = 1'b0;
    data1 = '0;
    data2 = '0;
    for (int p = 0; p < numWb; p++) begin
      if (wbValid_i[p] && (wbTag_i[p] == byp.srcTag1)) begin
        hit1  = 1'b1;
        data1 = wbData_i[p];
      end
      if (wbValid_i[p] && (wbTag_i[p] == byp.srcTag2)) begin
        hit2  = 1'b1;
        data2 = wbData_i[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      byp.bypHit1 <= 1'b0;
      byp.bypHit2 <= 1'b0;
    end else if (byp.stepEn) begin
      byp.bypHit1 <= hit1;
      byp.bypHit2 <= hit2;
    end
  end

  always_ff @(posedge clk) begin
    if (byp.stepEn) begin
      byp.bypData1 <= data1;
      byp.bypData2 <= data2;
    end
  end

endmodule

`default_nettype wire

/* verilog/physRegFile.sv */
// Physical register file with one write per writeback port and a registered two-operand read
`timescale 1ns/100ps
`default_nettype none

module physRegFile #(
  parameter int numPreg = regReadPkg::NUM_PREG,
  parameter int numWb   = regReadPkg::NUM_WB
) (
  input wire                                   clk,
  input wire                                   rst_i,
  input wire [numWb-1:0]                       wbValid_i,
  input wire regReadPkg::pregTag_t [numWb-1:0] wbTag_i,
  input wire regReadPkg::regData_t [numWb-1:0] wbData_i,
  readStageIf.regFile                          rd
);

  regReadPkg::regData_t regs [numPreg];

  // **********************************************************
  // Write side
  // **********************************************************
  // Later ports in the loop overwrite earlier ones, so the highest port wins
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < numPreg; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int p = 0; p < numWb; p++) begin
        if (wbValid_i[p]) begin
          regs[wbTag_i[p]] <= wbData_i[p];
        end
      end
    end
  end

  // **********************************************************
  // Read side
  // **********************************************************
  always_ff @(posedge clk) begin
    if (rd.stepEn) begin  // Holds its data while the pipe is stalled
      rd.fileData1 <= regs[rd.srcTag1];
      rd.fileData2 <= regs[rd.srcTag2];
    end
  end

endmodule

`default_nettype wire

/* verilog/readStageIf.sv */
// Bundle between operandMerge and the two operand sources, connected once at the top level
`timescale 1ns/100ps
`default_nettype none

interface readStageIf;

  regReadPkg::pregTag_t srcTag1;
  regReadPkg::pregTag_t srcTag2;
  logic                 stepEn;     // Pipe advances this cycle

  regReadPkg::regData_t fileData1;
  regReadPkg::regData_t fileData2;

  logic                 bypHit1;
  logic                 bypHit2;
  regReadPkg::regData_t bypData1;
  regReadPkg::regData_t bypData2;

  modport regFile (input srcTag1, srcTag2, stepEn, output fileData1, fileData2);
  modport bypass (input srcTag1, srcTag2, stepEn, output bypHit1, bypHit2, bypData1, bypData2);
  modport merge (output srcTag1, srcTag2, stepEn,
                 input fileData1, fileData2, bypHit1, bypHit2, bypData1, bypData2);

endinterface

`default_nettype wire

/* verilog/branchPkg.sv */
// Branch checkpoint types used by the squash logic of the read stage
`default_nettype none

package branchPkg;

  localparam int NUM_CKPT = 4;

  // Checkpoint of the branch that resolved this cycle
  typedef logic [$clog2(NUM_CKPT)-1:0] ckptId_t;

  typedef logic [NUM_CKPT-1:0] branchMask_t;  // Bit set for every branch still unresolved

endpackage

`default_nettype wire

/* verilog/regReadPkg.sv */
// Register widths and operand types that every read-stage module references by scoped name
`default_nettype none

package regReadPkg;

  // **********************************************************
  // Sizes of the read stage
  // **********************************************************
  localparam int NUM_PREG = 32;
  localparam int NUM_ARCH = 8;    // Ready straight out of reset
  localparam int DATA_W   = 32;
  localparam int NUM_WB   = 2;
  localparam int TAG_W    = $clog2(NUM_PREG);

  // **********************************************************
  // Types
  // **********************************************************
  typedef logic [TAG_W-1:0]    pregTag_t;   // Physical register name
  typedef logic [DATA_W-1:0]   regData_t;
  typedef logic [NUM_PREG-1:0] pregVec_t;   // One flag per physical register

endpackage

`default_nettype wire
